// File: Makefile
# Verilator build and run for the calibration path testbench

VERILATOR ?= verilator
TOP       ?= calib_tb
FILELIST  ?= calib_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SRCS      := $(wildcard rtl/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q ">>> PASS" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/calib_tb.sv
/*
  testbench for the calibration path top level
  lfsr samples, bus traffic to both blocks, reference model
  and concurrent assertions against the model
*/
`timescale 1ns/100ps

module calib_tb;

localparam int len_cfg  = 200;  // samples after the config writes
localparam int len_sat  = 200;  // extreme samples, clipping gains
localparam int len_peak = 300;  // random samples into the monitor
localparam int run_len  = len_cfg + len_sat + len_peak + 300;  // + bus traffic
localparam int timeout_cycles = 4 * run_len;

logic                           clk;
logic                           rstn;
cal_pkg::sys_req_t              sys_req;
cal_pkg::sys_rsp_t              sys_rsp;
logic signed [cal_pkg::dws-1:0] adc_in  [2];
logic signed [cal_pkg::dws-1:0] dac_in  [2];
logic signed [cal_pkg::dws-1:0] adc_out [2];
logic signed [cal_pkg::dws-1:0] dac_out [2];

// model state, channel 0-1 adc and 2-3 dac
logic signed [cal_pkg::dwm-1:0] mgain  [4];
logic signed [cal_pkg::dws-1:0] moffs  [4];
logic signed [cal_pkg::dws-1:0] exp_q1 [4];  // first pipeline cycle
logic signed [cal_pkg::dws-1:0] exp_q2 [4];  // expected outputs
logic signed [cal_pkg::dws-1:0] pk_min [2];
logic signed [cal_pkg::dws-1:0] pk_max [2];
logic        exp_ack_q;
logic        exp_err_q;
logic [31:0] exp_rd_q;

logic [31:0] lfsr;
logic        extreme;       // sample mode, extremes mixed in
int          cycles   = 0;
int          smp_errs = 0;
int          bus_errs = 0;
int          sat_hi   = 0;
int          sat_lo   = 0;

calib_top DUT (
  .clk     (clk),
  .rstn    (rstn),
  .sys_req (sys_req),
  .sys_rsp (sys_rsp),
  .adc_in  (adc_in),
  .dac_in  (dac_in),
  .adc_out (adc_out),
  .dac_out (dac_out)
);

initial begin
  clk = 1'b0;
  forever #2 clk = ~clk;  // 4 ns period
end

//////////////////////////////////////////////////////////////////////
// random source
//////////////////////////////////////////////////////////////////////

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [15:0] take_bits(input int n);
  logic [15:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = lfsr_next(lfsr);  // one step per bit
    v    = {v[14:0], lfsr[0]};
  end
  return v;
endfunction

function automatic logic signed [cal_pkg::dws-1:0] next_sample(input logic ext);
  logic [15:0] raw;
  logic [15:0] pick;
  raw = take_bits(cal_pkg::dws);
  if (ext) begin
    pick = take_bits(2);
    if (pick == 16'd0) return cal_pkg::smp_max;  // full scale high
    if (pick == 16'd1) return cal_pkg::smp_min;
  end
  return raw[cal_pkg::dws-1:0];
endfunction

// free-running sample streams, one per clock
initial begin
  lfsr = 32'he2cc;
  for (int i = 0; i < 2; i++) begin
    adc_in[i] = '0;
    dac_in[i] = '0;
  end
  forever begin
    @(posedge clk);
    for (int i = 0; i < 2; i++) begin
      adc_in[i] <= next_sample(extreme);
      dac_in[i] <= next_sample(extreme);
    end
  end
end

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////

// gain in Q2.14: product, floor shift, add offset, clip to 14 bits
function automatic logic signed [cal_pkg::dws-1:0] scale_ref(
  input logic signed [cal_pkg::dws-1:0] x,
  input logic signed [cal_pkg::dwm-1:0] g,
  input logic signed [cal_pkg::dws-1:0] o
);
  longint v;
  v = longint'(x) * longint'(g);
  v = (v >>> (cal_pkg::dwm - 2)) + longint'(o);
  if (v > longint'(cal_pkg::smp_max)) return cal_pkg::smp_max;
  if (v < longint'(cal_pkg::smp_min)) return cal_pkg::smp_min;
  return v[cal_pkg::dws-1:0];
endfunction

function automatic logic [31:0] sext_smp(input logic signed [cal_pkg::dws-1:0] s);
  return {{(32 - cal_pkg::dws){s[cal_pkg::dws-1]}}, s};
endfunction

// read data the bus should return for addr
function automatic logic [31:0] model_rdata(input logic [31:0] addr);
  logic [19:0] off;
  logic [1:0]  ch;
  off = addr[19:0];
  ch  = off[4:3];  // 0x40 + 8*ch
  if (addr[23:20] == 4'd0 && off[19:5] == 15'd2 && off[1:0] == 2'd0) begin
    if (off[2]) return sext_smp(moffs[ch]);
    return {{(32 - cal_pkg::dwm){mgain[ch][cal_pkg::dwm-1]}}, mgain[ch]};
  end
  if (addr[23:20] == 4'd1 && off[19:4] == 16'd0 && off[1:0] == 2'd0) begin
    case (off[3:2])
      2'd0:    return sext_smp(pk_min[0]);
      2'd1:    return sext_smp(pk_max[0]);
      2'd2:    return sext_smp(pk_min[1]);
      default: return sext_smp(pk_max[1]);
    endcase
  end
  return '0;  // holes and unmapped blocks
endfunction

always @(posedge clk) begin
  logic [19:0] off;
  logic        req;
  off = sys_req.addr[19:0];
  req = sys_req.wen | sys_req.ren;
  for (int i = 0; i < 2; i++) begin
    exp_q1[i]     <= scale_ref(adc_in[i], mgain[i], moffs[i]);
    exp_q1[i + 2] <= scale_ref(dac_in[i], mgain[i + 2], moffs[i + 2]);
  end
  for (int c = 0; c < 4; c++) begin
    exp_q2[c] <= rstn ? exp_q1[c] : '0;
    if (rstn && exp_q2[c] == cal_pkg::smp_max) sat_hi++;
    if (rstn && exp_q2[c] == cal_pkg::smp_min) sat_lo++;
  end
  // calibration words, live from the write edge on
  if (!rstn) begin
    for (int c = 0; c < 4; c++) begin
      mgain[c] <= cal_pkg::unity_gain;
      moffs[c] <= '0;
    end
  end else if (sys_req.wen && sys_req.addr[23:20] == 4'd0 &&
               off[19:5] == 15'd2 && off[1:0] == 2'd0) begin
    if (off[2]) moffs[off[4:3]] <= sys_req.wdata[cal_pkg::dws-1:0];
    else        mgain[off[4:3]] <= sys_req.wdata[cal_pkg::dwm-1:0];
  end
  // monitor sees the previous calibrated output
  if (!rstn || (sys_req.wen && sys_req.addr[23:0] == 24'h100010)) begin
    for (int i = 0; i < 2; i++) begin
      pk_min[i] <= cal_pkg::smp_max;
      pk_max[i] <= cal_pkg::smp_min;
    end
  end else begin
    for (int i = 0; i < 2; i++) begin
      if (exp_q2[i] < pk_min[i]) pk_min[i] <= exp_q2[i];
      if (exp_q2[i] > pk_max[i]) pk_max[i] <= exp_q2[i];
    end
  end
  exp_ack_q <= rstn & req;
  exp_err_q <= rstn & req & (sys_req.addr[23:20] > 4'd1);  // no block there
  exp_rd_q  <= sys_req.ren ? model_rdata(sys_req.addr) : '0;
end

//////////////////////////////////////////////////////////////////////
// checks
//////////////////////////////////////////////////////////////////////

for (genvar i = 0; i < 2; i++) begin : g_out_chk
  adc_chk: assert property (@(posedge clk) disable iff (!rstn) adc_out[i] == exp_q2[i])
    else begin
      smp_errs++;
      $display("** Error %0.1f ns: adc_out[%0d] expected %0d got %0d",
        $realtime, i, $sampled(exp_q2[i]), $sampled(adc_out[i]));
    end
  dac_chk: assert property (@(posedge clk) disable iff (!rstn) dac_out[i] == exp_q2[i + 2])
    else begin
      smp_errs++;
      $display("** Error %0.1f ns: dac_out[%0d] expected %0d got %0d",
        $realtime, i, $sampled(exp_q2[i + 2]), $sampled(dac_out[i]));
    end
end

ack_chk: assert property (@(posedge clk) disable iff (!rstn) sys_rsp.ack == exp_ack_q)
  else begin
    bus_errs++;
    $display("** Error %0.1f ns: sys_rsp.ack expected %b got %b",
      $realtime, $sampled(exp_ack_q), $sampled(sys_rsp.ack));
  end

err_chk: assert property (@(posedge clk) disable iff (!rstn) sys_rsp.err == exp_err_q)
  else begin
    bus_errs++;
    $display("** Error %0.1f ns: sys_rsp.err expected %b got %b",
      $realtime, $sampled(exp_err_q), $sampled(sys_rsp.err));
  end

rdata_chk: assert property (@(posedge clk) disable iff (!rstn) sys_rsp.rdata == exp_rd_q)
  else begin
    bus_errs++;
    $display("** Error %0.1f ns: sys_rsp.rdata expected %h got %h",
      $realtime, $sampled(exp_rd_q), $sampled(sys_rsp.rdata));
  end

//////////////////////////////////////////////////////////////////////
// bus master
//////////////////////////////////////////////////////////////////////

task automatic run_cycles(input int n);
  repeat (n) @(posedge clk);
endtask

// called on a rising edge, returns on the edge after ack
task automatic wait_ack(input logic [31:0] addr);
  int n;
  n = 0;
  @(negedge clk);  // ack is stable mid cycle
  while (!sys_rsp.ack && n < 4) begin
    @(negedge clk);
    n++;
  end
  if (!sys_rsp.ack) begin
    bus_errs++;
    $display("bus request to %h was never acknowledged", addr);
  end
  @(posedge clk);
endtask

task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] data);
  sys_req.addr  <= addr;
  sys_req.wdata <= data;
  sys_req.sel   <= 4'hf;
  sys_req.wen   <= wr;
  sys_req.ren   <= ~wr;
  @(posedge clk);   // DUT takes the request here
  sys_req.wen <= 1'b0;
  sys_req.ren <= 1'b0;
  wait_ack(addr);
endtask

task automatic write_cfg(input int ch, input logic [31:0] gain, input logic [31:0] offs);
  bus_access(1'b1, 32'h40 + 32'(8 * ch), gain);
  bus_access(1'b1, 32'h44 + 32'(8 * ch), offs);
endtask

task automatic read_all_cfg();
  for (int k = 0; k < 8; k++) bus_access(1'b0, 32'h40 + 32'(4 * k), '0);
endtask

// read issued right behind the clear, sees the empty state
task automatic clear_then_read(input logic [19:0] off);
  sys_req.addr <= 32'h0010_0010;
  sys_req.wen  <= 1'b1;
  sys_req.ren  <= 1'b0;
  @(posedge clk);
  sys_req.addr <= {12'h001, off};
  sys_req.wen  <= 1'b0;
  sys_req.ren  <= 1'b1;
  @(posedge clk);
  sys_req.ren <= 1'b0;
  wait_ack({12'h001, off});
endtask

//////////////////////////////////////////////////////////////////////
// test sequence
//////////////////////////////////////////////////////////////////////

initial begin
  sys_req = '0;
  rstn    = 1'b0;
  extreme = 1'b0;
  repeat (10) @(posedge clk);
  rstn <= 1'b1;
  run_cycles(4);
  read_all_cfg();                    // unity gains, zero offsets
  // signed words, upper wdata bits dropped
  write_cfg(0, 32'h0000_6000, 32'h0000_0100);
  write_cfg(1, 32'habcd_c000, 32'h0000_3f00);
  write_cfg(2, 32'h0000_2000, 32'h0000_3fff);
  write_cfg(3, 32'h0000_0123, 32'h0000_1000);
  read_all_cfg();
  run_cycles(len_cfg);
  // clipping both ways
  extreme <= 1'b1;
  write_cfg(0, 32'h0000_7fff, 32'h0000_1fff);
  write_cfg(1, 32'h0000_8000, 32'h0000_2000);
  write_cfg(2, 32'h0000_7fff, 32'h0000_2000);
  write_cfg(3, 32'h0000_8000, 32'h0000_1fff);
  run_cycles(len_sat);
  // peak monitor on random data
  extreme <= 1'b0;
  write_cfg(0, 32'h0000_3000, 32'h0000_0040);
  write_cfg(1, 32'h0000_5000, 32'h0000_3fc0);
  clear_then_read(20'h00);
  run_cycles(len_peak);
  for (int k = 0; k < 4; k++) bus_access(1'b0, 32'h0010_0000 + 32'(4 * k), '0);
  bus_access(1'b0, 32'h0010_0010, '0);  // clear reg reads zero
  clear_then_read(20'h04);
  clear_then_read(20'h08);
  clear_then_read(20'h0c);
  // holes and an empty block select
  bus_access(1'b0, 32'h0000_0000, '0);
  bus_access(1'b1, 32'h0000_0060, 32'h0000_1234);
  bus_access(1'b0, 32'h0050_0044, '0);
  bus_access(1'b1, 32'h0050_0000, 32'h0000_5555);
  run_cycles(8);
  if (sat_hi == 0 || sat_lo == 0) begin
    smp_errs++;
    $display("the saturation limits were never reached by the samples");
  end
  $display("errors: %0d sample, %0d bus (clip hits %0d high, %0d low)",
    smp_errs, bus_errs, sat_hi, sat_lo);
  if (smp_errs == 0 && bus_errs == 0) begin
    $display(">>> PASS");
  end else begin
    $display(">>> FAIL");
  end
  $finish;
end

// hang guard
initial begin
  while (cycles < timeout_cycles) begin
    @(posedge clk);
    cycles++;
  end
  $display("run stopped after %0d cycles without finishing", cycles);
  $display(">>> FAIL");
  $finish;
end

endmodule

// File: calib_top.f
rtl/cal_pkg.sv
rtl/sys_bus_decoder.sv
rtl/calib_regs.sv
rtl/calib_scale.sv
rtl/peak_monitor.sv
rtl/calib_top.sv
bench/calib_tb.sv

// File: rtl/cal_pkg.sv
/*
  calibration path shared definitions
  sample and gain widths, system bus address map,
  per-channel calibration word and bus request/response structs
*/
package cal_pkg;

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

localparam int dwm = 16;  // gain word
localparam int dws = 14;  // offset word and every sample

localparam int bus_aw = 32;  // bus address
localparam int bus_dw = 32;  // bus data
localparam int bus_sw = 4;   // byte select

// gain is signed fixed point, unity at 1 << (dwm-2)
localparam logic signed [dwm-1:0] unity_gain = dwm'(1 << (dwm - 2));

// sample range limits for saturation
localparam logic signed [dws-1:0] smp_max = {1'b0, {(dws - 1){1'b1}}};
localparam logic signed [dws-1:0] smp_min = {1'b1, {(dws - 1){1'b0}}};

//////////////////////////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////////////////////////

// block select lives in addr[23:20]
localparam logic [3:0] blk_calib = 4'd0;
localparam logic [3:0] blk_peak  = 4'd1;

// calibration registers, addr[19:0]
localparam logic [19:0] off_adc0_gain = 20'h40;
localparam logic [19:0] off_adc0_offs = 20'h44;
localparam logic [19:0] off_adc1_gain = 20'h48;
localparam logic [19:0] off_adc1_offs = 20'h4C;
localparam logic [19:0] off_dac0_gain = 20'h50;
localparam logic [19:0] off_dac0_offs = 20'h54;
localparam logic [19:0] off_dac1_gain = 20'h58;
localparam logic [19:0] off_dac1_offs = 20'h5C;

// peak monitor
localparam logic [19:0] off_pk_adc0_min = 20'h00;
localparam logic [19:0] off_pk_adc0_max = 20'h04;
localparam logic [19:0] off_pk_adc1_min = 20'h08;
localparam logic [19:0] off_pk_adc1_max = 20'h0C;
localparam logic [19:0] off_pk_clear    = 20'h10;  // write only

//////////////////////////////////////////////////////////////////////
// structs
//////////////////////////////////////////////////////////////////////

// one channel of calibration, 30 bits
typedef struct packed {
  logic signed [dwm-1:0] gain;
  logic signed [dws-1:0] offs;
} cal_cfg_t;

// bus request, strobes are single-cycle pulses
typedef struct packed {
  logic [bus_aw-1:0] addr;
  logic [bus_dw-1:0] wdata;
  logic [bus_sw-1:0] sel;   // carried, writes are always full word
  logic              wen;
  logic              ren;
} sys_req_t;

// bus response, one cycle after the request
typedef struct packed {
  logic [bus_dw-1:0] rdata;
  logic              err;
  logic              ack;
} sys_rsp_t;

endpackage

// File: rtl/calib_regs.sv
/*
  calibration register block
  gain and offset words for two ADC and two DAC channels,
  bus writable and readable with a fixed one-cycle ack
*/
`timescale 1ns/100ps

module calib_regs (
  input  logic              clk,
  input  logic              rstn,
  // bus
  input  cal_pkg::sys_req_t req,
  output cal_pkg::sys_rsp_t rsp,
  // calibration out to the scale stages
  output cal_pkg::cal_cfg_t adc_cfg [2],
  output cal_pkg::cal_cfg_t dac_cfg [2]
);

logic [19:0]                 offs;    // register offset within block
logic [cal_pkg::bus_dw-1:0]  rd_mux;  // read data before the register

assign offs = req.addr[19:0];

//////////////////////////////////////////////////////////////////////
// register writes
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
  if (!rstn) begin
    for (int i = 0; i < 2; i++) begin
      adc_cfg[i].gain <= cal_pkg::unity_gain;  // pass-through
      adc_cfg[i].offs <= '0;
      dac_cfg[i].gain <= cal_pkg::unity_gain;
      dac_cfg[i].offs <= '0;
    end
  end else if (req.wen) begin
    // only the low bits of wdata are kept
    case (offs)
      cal_pkg::off_adc0_gain: adc_cfg[0].gain <= req.wdata[cal_pkg::dwm-1:0];
      cal_pkg::off_adc0_offs: adc_cfg[0].offs <= req.wdata[cal_pkg::dws-1:0];
      cal_pkg::off_adc1_gain: adc_cfg[1].gain <= req.wdata[cal_pkg::dwm-1:0];
      cal_pkg::off_adc1_offs: adc_cfg[1].offs <= req.wdata[cal_pkg::dws-1:0];
      cal_pkg::off_dac0_gain: dac_cfg[0].gain <= req.wdata[cal_pkg::dwm-1:0];
      cal_pkg::off_dac0_offs: dac_cfg[0].offs <= req.wdata[cal_pkg::dws-1:0];
      cal_pkg::off_dac1_gain: dac_cfg[1].gain <= req.wdata[cal_pkg::dwm-1:0];
      cal_pkg::off_dac1_offs: dac_cfg[1].offs <= req.wdata[cal_pkg::dws-1:0];
      default: ;  // unmapped write is acked and dropped
    endcase
  end
end

//////////////////////////////////////////////////////////////////////
// register reads
//////////////////////////////////////////////////////////////////////

// sign extended to the bus width
always_comb begin
  case (offs)
    cal_pkg::off_adc0_gain: rd_mux = 32'(adc_cfg[0].gain);
    cal_pkg::off_adc0_offs: rd_mux = 32'(adc_cfg[0].offs);
    cal_pkg::off_adc1_gain: rd_mux = 32'(adc_cfg[1].gain);
    cal_pkg::off_adc1_offs: rd_mux = 32'(adc_cfg[1].offs);
    cal_pkg::off_dac0_gain: rd_mux = 32'(dac_cfg[0].gain);
    cal_pkg::off_dac0_offs: rd_mux = 32'(dac_cfg[0].offs);
    cal_pkg::off_dac1_gain: rd_mux = 32'(dac_cfg[1].gain);
    cal_pkg::off_dac1_offs: rd_mux = 32'(dac_cfg[1].offs);
    default:                rd_mux = '0;  // holes read as zero
  endcase
end

always_ff @(posedge clk) begin
  if (!rstn) begin
    rsp <= '0;
  end else begin
    rsp.rdata <= req.ren ? rd_mux : '0;  // zero when idle, decoder ORs
    rsp.err   <= 1'b0;                   // never errors inside the block
    rsp.ack   <= req.wen | req.ren;
  end
end

// every request answered next cycle and never with an error
req_ack: assert property (@(posedge clk) disable iff (!rstn)
  (req.wen || req.ren) |=> (rsp.ack && !rsp.err));

endmodule

// File: rtl/calib_scale.sv
/*
  gain, offset and saturation stage for one sample stream
  two pipeline registers, product first then shift, offset and clip
*/
`timescale 1ns/100ps

module calib_scale (
  input  logic                           clk,
  input  logic                           rstn,
  input  cal_pkg::cal_cfg_t              cfg,   // gain and offset
  input  logic signed [cal_pkg::dws-1:0] din,   // one sample per clock
  output logic signed [cal_pkg::dws-1:0] dout   // din two cycles later, calibrated
);

logic signed [cal_pkg::dwm+cal_pkg::dws-1:0] prod;    // full width product
logic signed [cal_pkg::dws-1:0]              offs_q;  // offset travelling with prod
logic signed [cal_pkg::dwm+cal_pkg::dws:0]   sum;     // guard bit above product

//////////////////////////////////////////////////////////////////////
// stage one, multiply
//////////////////////////////////////////////////////////////////////

// offset is captured with the product so one sample never
// mixes an old gain with a new offset
always_ff @(posedge clk) begin
  prod   <= din * cfg.gain;
  offs_q <= cfg.offs;
end

//////////////////////////////////////////////////////////////////////
// stage two, rescale, add offset, saturate
//////////////////////////////////////////////////////////////////////

// arithmetic shift drops the fixed point fraction
// (floors toward minus infinity)
assign sum = (prod >>> (cal_pkg::dwm - 2)) + offs_q;

always_ff @(posedge clk) begin
  if (!rstn) begin
    dout <= '0;
  end else if (sum > cal_pkg::smp_max) begin
    dout <= cal_pkg::smp_max;           // clip high
  end else if (sum < cal_pkg::smp_min) begin
    dout <= cal_pkg::smp_min;           // clip low
  end else begin
    dout <= sum[cal_pkg::dws-1:0];      // in range, plain truncation
  end
end

// an in-range sum must come through unchanged
sat_pass: assert property (@(posedge clk) disable iff (!rstn)
  (rstn && sum >= cal_pkg::smp_min && sum <= cal_pkg::smp_max)
  |=> (dout == $signed($past(sum[cal_pkg::dws-1:0]))));

endmodule

// File: rtl/calib_top.sv
/*
  analog front-end calibration top
  bus decoder, calibration registers, four gain/offset stages
  and the ADC peak monitor
*/
`timescale 1ns/100ps

module calib_top (
  input  logic                           clk,
  input  logic                           rstn,
  // system bus
  input  cal_pkg::sys_req_t              sys_req,
  output cal_pkg::sys_rsp_t              sys_rsp,
  // sample streams
  input  logic signed [cal_pkg::dws-1:0] adc_in  [2],
  input  logic signed [cal_pkg::dws-1:0] dac_in  [2],
  output logic signed [cal_pkg::dws-1:0] adc_out [2],
  output logic signed [cal_pkg::dws-1:0] dac_out [2]
);

cal_pkg::sys_req_t calib_req;  // decoder to register block
cal_pkg::sys_req_t peak_req;   // decoder to monitor
cal_pkg::sys_rsp_t calib_rsp;
cal_pkg::sys_rsp_t peak_rsp;
cal_pkg::cal_cfg_t adc_cfg [2];
cal_pkg::cal_cfg_t dac_cfg [2];

//////////////////////////////////////////////////////////////////////
// bus side
//////////////////////////////////////////////////////////////////////

sys_bus_decoder u_dec (
  .clk       (clk),
  .rstn      (rstn),
  .req       (sys_req),
  .rsp       (sys_rsp),
  .calib_req (calib_req),
  .peak_req  (peak_req),
  .calib_rsp (calib_rsp),
  .peak_rsp  (peak_rsp)
);

calib_regs u_regs (
  .clk     (clk),
  .rstn    (rstn),
  .req     (calib_req),
  .rsp     (calib_rsp),
  .adc_cfg (adc_cfg),
  .dac_cfg (dac_cfg)
);

//////////////////////////////////////////////////////////////////////
// sample paths
//////////////////////////////////////////////////////////////////////

// one stage per converter channel
for (genvar i = 0; i < 2; i++) begin : g_ch
  calib_scale u_adc_scale (
    .clk  (clk),
    .rstn (rstn),
    .cfg  (adc_cfg[i]),
    .din  (adc_in[i]),
    .dout (adc_out[i])
  );

  calib_scale u_dac_scale (
    .clk  (clk),
    .rstn (rstn),
    .cfg  (dac_cfg[i]),
    .din  (dac_in[i]),
    .dout (dac_out[i])
  );
end

// watches the calibrated ADC streams only
peak_monitor u_peak (
  .clk  (clk),
  .rstn (rstn),
  .req  (peak_req),
  .rsp  (peak_rsp),
  .adc  (adc_out)
);

endmodule

// File: rtl/peak_monitor.sv
/*
  peak monitor for the calibrated ADC channels
  running minimum and maximum per channel, bus readable,
  cleared back to the empty state by a bus write
*/
`timescale 1ns/100ps

module peak_monitor (
  input  logic                           clk,
  input  logic                           rstn,
  // bus
  input  cal_pkg::sys_req_t              req,
  output cal_pkg::sys_rsp_t              rsp,
  // calibrated ADC samples
  input  logic signed [cal_pkg::dws-1:0] adc [2]
);

logic signed [cal_pkg::dws-1:0] mn [2];  // running minimum
logic signed [cal_pkg::dws-1:0] mx [2];  // running maximum
logic [19:0]                    offs;
logic                           clr;     // clear strobe from bus
logic [cal_pkg::bus_dw-1:0]     rd_mux;

assign offs = req.addr[19:0];
assign clr  = req.wen && (offs == cal_pkg::off_pk_clear);

//////////////////////////////////////////////////////////////////////
// min/max tracking
//////////////////////////////////////////////////////////////////////

// empty state is min at top of range, max at bottom
always_ff @(posedge clk) begin
  if (!rstn || clr) begin
    for (int i = 0; i < 2; i++) begin
      mn[i] <= cal_pkg::smp_max;
      mx[i] <= cal_pkg::smp_min;
    end
  end else begin
    for (int i = 0; i < 2; i++) begin
      if (adc[i] < mn[i]) mn[i] <= adc[i];  // new low
      if (adc[i] > mx[i]) mx[i] <= adc[i];  // new high
    end
  end
end

//////////////////////////////////////////////////////////////////////
// bus side
//////////////////////////////////////////////////////////////////////

always_comb begin
  case (offs)
    cal_pkg::off_pk_adc0_min: rd_mux = 32'(mn[0]);
    cal_pkg::off_pk_adc0_max: rd_mux = 32'(mx[0]);
    cal_pkg::off_pk_adc1_min: rd_mux = 32'(mn[1]);
    cal_pkg::off_pk_adc1_max: rd_mux = 32'(mx[1]);
    default:                  rd_mux = '0;  // clear reg reads zero too
  endcase
end

always_ff @(posedge clk) begin
  if (!rstn) begin
    rsp <= '0;
  end else begin
    rsp.rdata <= req.ren ? rd_mux : '0;
    rsp.err   <= 1'b0;
    rsp.ack   <= req.wen | req.ren;
  end
end

// one sample after reset or clear the range is never inverted
range_ok: assert property (@(posedge clk) disable iff (!rstn)
  (rstn && !clr) |=> ((mn[0] <= mx[0]) && (mn[1] <= mx[1])));

endmodule

// File: rtl/sys_bus_decoder.sv
/*
  system bus decoder
  routes each request to the calibration registers or the peak monitor
  by block select, merges their responses and errors out unmapped blocks
*/
`timescale 1ns/100ps

module sys_bus_decoder (
  input  logic              clk,
  input  logic              rstn,
  // from the bus master
  input  cal_pkg::sys_req_t req,
  output cal_pkg::sys_rsp_t rsp,
  // to the subordinate blocks
  output cal_pkg::sys_req_t calib_req,
  output cal_pkg::sys_req_t peak_req,
  input  cal_pkg::sys_rsp_t calib_rsp,
  input  cal_pkg::sys_rsp_t peak_rsp
);

logic [3:0] blk;        // block select field
logic       sel_calib;
logic       sel_peak;
logic       req_en;     // any request this cycle
logic       err_q;      // registered error response

//////////////////////////////////////////////////////////////////////
// request routing
//////////////////////////////////////////////////////////////////////

assign blk       = req.addr[23:20];
assign sel_calib = (blk == cal_pkg::blk_calib);
assign sel_peak  = (blk == cal_pkg::blk_peak);
assign req_en    = req.wen | req.ren;

// address and data go everywhere, only strobes are gated
always_comb begin
  calib_req     = req;
  calib_req.wen = req.wen & sel_calib;
  calib_req.ren = req.ren & sel_calib;
  peak_req      = req;
  peak_req.wen  = req.wen & sel_peak;
  peak_req.ren  = req.ren & sel_peak;
end

// nobody home at this block select
always_ff @(posedge clk) begin
  if (!rstn) begin
    err_q <= 1'b0;
  end else begin
    err_q <= req_en & ~(sel_calib | sel_peak);
  end
end

//////////////////////////////////////////////////////////////////////
// response merge
//////////////////////////////////////////////////////////////////////

// idle blocks return all zero so a plain OR is enough
always_comb begin
  rsp.rdata = calib_rsp.rdata | peak_rsp.rdata;  // err response has no data
  rsp.err   = calib_rsp.err | peak_rsp.err | err_q;
  rsp.ack   = calib_rsp.ack | peak_rsp.ack | err_q;
end

// only one source may answer in a cycle
ack_onehot: assert property (@(posedge clk) disable iff (!rstn)
  $onehot0({calib_rsp.ack, peak_rsp.ack, err_q}));

// whichever block is selected, the master sees ack one cycle later
ack_latency: assert property (@(posedge clk) disable iff (!rstn)
  req_en |=> rsp.ack);

endmodule
